/* Makefile */
SRCS = $(wildcard hdl/*.sv) tests/iosys_tb.sv

.PHONY: all run clean

all: obj_dir/Viosys_tb

obj_dir/Viosys_tb: $(SRCS) list.f
	verilator --binary --timing --assert -f list.f --top-module iosys_tb -o Viosys_tb

run: obj_dir/Viosys_tb
	-./obj_dir/Viosys_tb | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/cpu_bus_if.sv */
`timescale 1ns/1ps

// CPU memory bus
// valid/ready handshake: the master holds its request steady while
// valid is high until it sees ready at a clock edge
interface cpu_bus_if;
    logic                     valid;
    logic                     ready;
    iosys_map_pkg::bus_addr_t addr;
    iosys_map_pkg::bus_data_t wdata;
    iosys_map_pkg::bus_strb_t wstrb;    // all zero for a read
    iosys_map_pkg::bus_data_t rdata;

    modport master (
        output valid, addr, wdata, wstrb,
        input  ready, rdata
    );
    modport slave (
        input  valid, addr, wdata, wstrb,
        output ready, rdata
    );
endinterface

/* hdl/flash_boot.sv */
`timescale 1ns/1ps

// flash boot loader
// once sdram init is over, reads the firmware image from spi flash
// (mode 0, wclk/2) and packs every byte pair into one sdram write
module flash_boot #(
    parameter int          fw_bytes      = 16,
    parameter logic [23:0] fw_flash_addr = 24'h50_0000
) (
    input  logic                       wclk,
    input  logic                       resetn,
    input  logic                       ram_busy,
    output logic                       spi_cs_n,
    output logic                       spi_clk,
    output logic                       spi_mosi,
    input  logic                       spi_miso,
    output logic                       boot_wr,
    output iosys_map_pkg::sdram_addr_t boot_addr,
    output iosys_map_pkg::sdram_data_t boot_data,
    output logic                       boot_done
);

    // command + 3 address bytes, then the image
    localparam int total_bits = 32 + 8 * fw_bytes;
    localparam int cnt_w      = $clog2(total_bits + 1);
    localparam logic [cnt_w-1:0] data_start = cnt_w'(32);
    localparam logic [cnt_w-1:0] last_bit   = cnt_w'(total_bits);
    localparam logic [cnt_w-4:0] hdr_bytes  = 4;

    logic [31:0]      tx_sr;
    logic [6:0]       rx_sr;
    logic [7:0]       rx_byte;
    logic [7:0]       lo_byte;      // first byte of the pair
    logic [cnt_w-1:0] bit_cnt;      // rising sck edges so far
    logic [cnt_w-4:0] byte_idx;
    logic             fin;

    // data byte currently coming in
    assign byte_idx = bit_cnt[cnt_w-1:3] - hdr_bytes;
    assign rx_byte  = {rx_sr, spi_miso};
    assign spi_mosi = tx_sr[31];

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            spi_cs_n  <= 1'b1;
            spi_clk   <= 1'b0;
            tx_sr     <= '0;
            bit_cnt   <= '0;
            boot_wr   <= 1'b0;
            fin       <= 1'b0;
            boot_done <= 1'b0;
        end else begin
            boot_wr   <= 1'b0;
            // done trails the last write so the bridge still forwards it
            boot_done <= boot_done | fin;
            if (spi_cs_n) begin
                spi_clk <= 1'b0;
                if (!fin && !ram_busy) begin
                    // mosi holds the first command bit a full cycle
                    spi_cs_n <= 1'b0;
                    tx_sr    <= {iosys_map_pkg::spi_read_cmd, fw_flash_addr};
                    bit_cnt  <= '0;
                end
            end else if (!spi_clk) begin
                // sck rises next and miso is sampled
                spi_clk <= 1'b1;
                rx_sr   <= rx_byte[6:0];
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt >= data_start && bit_cnt[2:0] == 3'd7) begin
                    if (!byte_idx[0]) begin
                        lo_byte <= rx_byte;
                    end else begin
                        // pair complete, written at the byte offset of its first byte
                        boot_wr   <= 1'b1;
                        boot_data <= {rx_byte, lo_byte};
                        boot_addr <= iosys_map_pkg::sdram_addr_t'({byte_idx[cnt_w-4:1], 1'b0});
                    end
                end
            end else begin
                // sck falls next and the next bit shifts out
                spi_clk <= 1'b0;
                tx_sr   <= {tx_sr[30:0], 1'b0};
                if (bit_cnt == last_bit) begin
                    spi_cs_n <= 1'b1;
                    fin      <= 1'b1;
                end
            end
        end
    end

    // done stays high with the flash released and no boot write after it
    assert property (@(posedge wclk) disable iff (!resetn)
        boot_done |=> boot_done && spi_cs_n && !boot_wr);

endmodule

/* hdl/iosys_core.sv */
`timescale 1ns/1ps

// iosys core
// boot and i/o core of the console i/o subsystem. decodes the cpu bus
// into sdram, overlay, joystick and rom-load registers, and holds the
// bus off until the firmware copy from flash is done
module iosys_core #(
    parameter int          fw_bytes      = 16,
    parameter logic [23:0] fw_flash_addr = 24'h50_0000
) (
    input  logic                       wclk,
    input  logic                       resetn,
    // cpu bus
    input  logic                       mem_valid,
    output logic                       mem_ready,
    input  iosys_map_pkg::bus_addr_t   mem_addr,
    input  iosys_map_pkg::bus_data_t   mem_wdata,
    input  iosys_map_pkg::bus_strb_t   mem_wstrb,
    output iosys_map_pkg::bus_data_t   mem_rdata,
    // sdram port
    output iosys_map_pkg::sdram_addr_t rv_addr,
    output iosys_map_pkg::sdram_data_t rv_din,
    output logic [1:0]                 rv_ds,
    input  iosys_map_pkg::sdram_data_t rv_dout,
    output logic                       rv_rd,
    output logic                       rv_wr,
    input  logic                       ram_busy,    // high during sdram init
    // spi flash
    output logic                       flash_spi_cs_n,
    output logic                       flash_spi_clk,
    output logic                       flash_spi_mosi,
    input  logic                       flash_spi_miso,
    // joysticks, 12 buttons each
    input  logic [11:0]                joy1,
    input  logic [11:0]                joy2,
    // rom loading
    output logic                       rom_loading,
    output logic [7:0]                 rom_do,
    output logic                       rom_do_valid,
    output logic [7:0]                 map_ctrl,
    output logic [3:0]                 rom_size,
    output logic [3:0]                 ram_size,
    output logic [23:0]                rom_mask,
    output logic [23:0]                ram_mask,
    output logic                       overlay,
    output logic                       boot_done
);

    cpu_bus_if ram_bus ();
    cpu_bus_if rom_bus ();

    logic                       boot_wr;
    iosys_map_pkg::sdram_addr_t boot_addr;
    iosys_map_pkg::sdram_data_t boot_data;
    logic                       req;
    logic                       sel_ram;
    logic                       sel_char;
    logic                       sel_joy;
    logic                       sel_romctrl;
    logic                       sel_romdata;

    // nothing reaches a slave before the firmware is in
    assign req         = mem_valid && boot_done;
    assign sel_ram     = mem_addr < iosys_map_pkg::sdram_limit;
    assign sel_char    = mem_addr == iosys_map_pkg::reg_char_addr;
    assign sel_joy     = mem_addr == iosys_map_pkg::reg_joy_addr;
    assign sel_romctrl = mem_addr == iosys_map_pkg::reg_romctrl_addr;
    assign sel_romdata = mem_addr == iosys_map_pkg::reg_romdata_addr;

    assign ram_bus.valid = req && sel_ram;
    assign ram_bus.addr  = mem_addr;
    assign ram_bus.wdata = mem_wdata;
    assign ram_bus.wstrb = mem_wstrb;

    assign rom_bus.valid = req && sel_romdata;
    assign rom_bus.addr  = mem_addr;
    assign rom_bus.wdata = mem_wdata;
    assign rom_bus.wstrb = mem_wstrb;

    // registers answer at once; sdram and a busy rom stream hold off
    assign mem_ready = req && (sel_ram ? ram_bus.ready :
                               sel_romdata ? rom_bus.ready : 1'b1);

    always_comb begin
        // char register and unmapped addresses read zero
        mem_rdata = '0;
        if (sel_ram) begin
            mem_rdata = ram_bus.rdata;
        end else if (sel_joy) begin
            mem_rdata = {4'd0, joy1, 4'd0, joy2};
        end else if (sel_romctrl || sel_romdata) begin
            mem_rdata = rom_bus.rdata;
        end
    end

    // overlay toggled through the char register, other codes leave it
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            overlay <= 1'b1;
        end else if (req && sel_char && mem_wstrb[0]) begin
            case (mem_wdata[25:24])
                iosys_map_pkg::overlay_on:  overlay <= 1'b1;
                iosys_map_pkg::overlay_off: overlay <= 1'b0;
                default: ;
            endcase
        end
    end

    flash_boot #(
        .fw_bytes      (fw_bytes),
        .fw_flash_addr (fw_flash_addr)
    ) boot (
        .wclk      (wclk),
        .resetn    (resetn),
        .ram_busy  (ram_busy),
        .spi_cs_n  (flash_spi_cs_n),
        .spi_clk   (flash_spi_clk),
        .spi_mosi  (flash_spi_mosi),
        .spi_miso  (flash_spi_miso),
        .boot_wr   (boot_wr),
        .boot_addr (boot_addr),
        .boot_data (boot_data),
        .boot_done (boot_done)
    );

    sdram_bridge bridge (
        .wclk      (wclk),
        .resetn    (resetn),
        .bus       (ram_bus.slave),
        .boot_wr   (boot_wr),
        .boot_addr (boot_addr),
        .boot_data (boot_data),
        .boot_done (boot_done),
        .rv_addr   (rv_addr),
        .rv_din    (rv_din),
        .rv_ds     (rv_ds),
        .rv_dout   (rv_dout),
        .rv_rd     (rv_rd),
        .rv_wr     (rv_wr)
    );

    rom_loader loader (
        .wclk         (wclk),
        .resetn       (resetn),
        .ctrl_sel     (req && sel_romctrl),
        .bus          (rom_bus.slave),
        .rom_loading  (rom_loading),
        .rom_do       (rom_do),
        .rom_do_valid (rom_do_valid),
        .map_ctrl     (map_ctrl),
        .rom_size     (rom_size),
        .ram_size     (ram_size),
        .rom_mask     (rom_mask),
        .ram_mask     (ram_mask)
    );

endmodule

/* hdl/iosys_map_pkg.sv */
// I/O subsystem address map
// bus word types, the sdram window, register addresses
// and the command codes used by the bus slaves
package iosys_map_pkg;

    // cpu bus words
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_strb_t;

    // sdram side, byte address into 8 MB of 16-bit words
    typedef logic [22:0] sdram_addr_t;
    typedef logic [15:0] sdram_data_t;

    // everything below this is sdram
    localparam bus_addr_t sdram_limit = 32'h0080_0000;

    // i/o registers, anything else up there reads zero
    localparam bus_addr_t reg_char_addr    = 32'h0200_0000;
    localparam bus_addr_t reg_romctrl_addr = 32'h0200_0010;
    localparam bus_addr_t reg_romdata_addr = 32'h0200_0014;
    localparam bus_addr_t reg_joy_addr     = 32'h0200_0018;

    // overlay codes, bits 25:24 of a char write
    localparam logic [1:0] overlay_on  = 2'd1;
    localparam logic [1:0] overlay_off = 2'd2;

    // spi flash plain read
    localparam logic [7:0] spi_read_cmd = 8'h03;

endpackage

/* hdl/iosys_rom_pkg.sv */
// ROM load header types
// the first data words of a rom load carry a 12-byte header, the rest
// is a byte stream; one 32-bit word is decoded either way
package iosys_rom_pkg;

    // header word 0: byte 0 map control, byte 1 rom size, byte 2 ram size
    typedef struct packed {
        logic [7:0] pad_hi;     // byte 3 unused
        logic [3:0] pad_ram;
        logic [3:0] ram_size;
        logic [3:0] pad_rom;
        logic [3:0] rom_size;
        logic [7:0] map_ctrl;
    } rom_hdr0_t;

    // byte 0 is the least significant, masks use bytes 2..0
    typedef union packed {
        rom_hdr0_t       hdr;
        logic [3:0][7:0] bytes;
    } rom_word_u;

    // where the next data write goes
    typedef enum logic [1:0] {
        hdr_ctrl,
        hdr_rom_mask,
        hdr_ram_mask,
        hdr_data
    } hdr_phase_t;

endpackage

/* hdl/rom_loader.sv */
`timescale 1ns/1ps

// rom loader
// rom-load control and data registers. the first three data words
// are the header (map control, sizes, masks), every later word goes
// out one byte per cycle, least significant first
module rom_loader (
    input  logic        wclk,
    input  logic        resetn,
    input  logic        ctrl_sel,
    cpu_bus_if.slave    bus,
    output logic        rom_loading,
    output logic [7:0]  rom_do,
    output logic        rom_do_valid,
    output logic [7:0]  map_ctrl,
    output logic [3:0]  rom_size,
    output logic [3:0]  ram_size,
    output logic [23:0] rom_mask,
    output logic [23:0] ram_mask
);

    iosys_rom_pkg::rom_word_u  word;
    iosys_rom_pkg::hdr_phase_t phase;
    logic [3:0][7:0]           do_buf;
    logic [1:0]                stream_cnt;  // bytes left after the current one
    logic                      data_wr;

    assign word   = bus.wdata;
    assign rom_do = do_buf[0];
    // data register stalls while a word is still going out
    assign bus.ready = bus.valid && stream_cnt == 2'd0;
    // status read, bit 0 loading
    assign bus.rdata = {31'd0, rom_loading};
    assign data_wr   = bus.valid && bus.ready && |bus.wstrb;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            rom_loading  <= 1'b0;
            rom_do_valid <= 1'b0;
            stream_cnt   <= 2'd0;
            phase        <= iosys_rom_pkg::hdr_ctrl;
        end else begin
            rom_do_valid <= 1'b0;
            // 1 starts a load, 0 ends it
            if (ctrl_sel && bus.wstrb[0]) begin
                if (bus.wdata[7:0] == 8'd1) begin
                    rom_loading <= 1'b1;
                    phase       <= iosys_rom_pkg::hdr_ctrl;
                end else if (bus.wdata[7:0] == 8'd0) begin
                    rom_loading <= 1'b0;
                end
            end
            if (stream_cnt != 2'd0) begin
                do_buf       <= {8'd0, do_buf[3:1]};
                stream_cnt   <= stream_cnt - 2'd1;
                rom_do_valid <= 1'b1;
            end
            if (data_wr) begin
                case (phase)
                    iosys_rom_pkg::hdr_ctrl: begin
                        map_ctrl <= word.hdr.map_ctrl;
                        rom_size <= word.hdr.rom_size;
                        ram_size <= word.hdr.ram_size;
                        phase    <= iosys_rom_pkg::hdr_rom_mask;
                    end
                    iosys_rom_pkg::hdr_rom_mask: begin
                        rom_mask <= word.bytes[2:0];
                        phase    <= iosys_rom_pkg::hdr_ram_mask;
                    end
                    iosys_rom_pkg::hdr_ram_mask: begin
                        ram_mask <= word.bytes[2:0];
                        phase    <= iosys_rom_pkg::hdr_data;
                    end
                    default: begin
                        // byte 0 shows next cycle
                        do_buf       <= word.bytes;
                        stream_cnt   <= 2'd3;
                        rom_do_valid <= 1'b1;
                    end
                endcase
            end
        end
    end

    // a data word owns the byte stream for its four cycles
    assert property (@(posedge wclk) disable iff (!resetn)
        (data_wr && phase == iosys_rom_pkg::hdr_data) |=> (!data_wr && rom_do_valid) [*3]);

endmodule

/* hdl/sdram_bridge.sv */
`timescale 1ns/1ps

// sdram bridge
// passes the boot writes through until the firmware copy is done,
// then splits each 32-bit cpu access into two 16-bit transfers
module sdram_bridge (
    input  logic                       wclk,
    input  logic                       resetn,
    cpu_bus_if.slave                   bus,
    input  logic                       boot_wr,
    input  iosys_map_pkg::sdram_addr_t boot_addr,
    input  iosys_map_pkg::sdram_data_t boot_data,
    input  logic                       boot_done,
    output iosys_map_pkg::sdram_addr_t rv_addr,
    output iosys_map_pkg::sdram_data_t rv_din,
    output logic [1:0]                 rv_ds,
    input  iosys_map_pkg::sdram_data_t rv_dout,
    output logic                       rv_rd,
    output logic                       rv_wr
);

    logic [1:0]                 step;       // 0 idle, 1..3 busy
    logic                       writing;
    logic                       ready_q;
    iosys_map_pkg::bus_data_t   rdata_q;
    // high half of a write waits here
    iosys_map_pkg::sdram_data_t din_hi;
    logic [1:0]                 ds_hi;

    assign bus.ready = ready_q;
    assign bus.rdata = rdata_q;

    // read data for a request issued at edge n is sampled at edge n+2
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            step    <= 2'd0;
            writing <= 1'b0;
            ready_q <= 1'b0;
            rv_rd   <= 1'b0;
            rv_wr   <= 1'b0;
        end else begin
            rv_rd   <= 1'b0;
            rv_wr   <= 1'b0;
            ready_q <= 1'b0;
            if (!boot_done) begin
                // boot copy owns the port, full half-words
                rv_addr <= boot_addr;
                rv_din  <= boot_data;
                rv_ds   <= 2'b11;
                rv_wr   <= boot_wr;
            end else begin
                case (step)
                    2'd0: begin
                        // ready_q still high: master is on the read just finished
                        if (bus.valid && !ready_q) begin
                            rv_addr <= {bus.addr[22:2], 2'b00};
                            writing <= |bus.wstrb;
                            if (|bus.wstrb) begin
                                // ack at once, low half goes out now
                                ready_q <= 1'b1;
                                rv_wr   <= 1'b1;
                                rv_din  <= bus.wdata[15:0];
                                rv_ds   <= bus.wstrb[1:0];
                                din_hi  <= bus.wdata[31:16];
                                ds_hi   <= bus.wstrb[3:2];
                            end else begin
                                rv_rd <= 1'b1;
                                rv_ds <= 2'b11;
                            end
                            step <= 2'd1;
                        end
                    end
                    2'd1: begin
                        // back-to-back read of the high half
                        if (!writing) begin
                            rv_rd   <= 1'b1;
                            rv_addr <= {rv_addr[22:2], 2'b10};
                        end
                        step <= 2'd2;
                    end
                    2'd2: begin
                        if (writing) begin
                            rv_wr   <= 1'b1;
                            rv_din  <= din_hi;
                            rv_ds   <= ds_hi;
                            rv_addr <= {rv_addr[22:2], 2'b10};
                        end else begin
                            rdata_q[15:0] <= rv_dout;
                        end
                        step <= 2'd3;
                    end
                    default: begin
                        if (!writing) begin
                            rdata_q[31:16] <= rv_dout;
                            ready_q        <= 1'b1;
                        end
                        step <= 2'd0;
                    end
                endcase
            end
        end
    end

    // boot mux and access sequencer never collide on the port
    assert property (@(posedge wclk) disable iff (!resetn) !(rv_rd && rv_wr));

endmodule

/* list.f */
hdl/iosys_map_pkg.sv
hdl/iosys_rom_pkg.sv
hdl/cpu_bus_if.sv
hdl/flash_boot.sv
hdl/sdram_bridge.sv
hdl/rom_loader.sv
hdl/iosys_core.sv
tests/iosys_tb.sv

/* tests/iosys_golden.txt */
# F: four firmware bytes | W: addr data strb | R: addr expected | J: joy1 joy2
# O/L: overlay/rom_loading | B: four rom bytes | M: map rom_size ram_size rom_mask ram_mask
F 12 34 56 78
F 9a bc de f0
F 01 23 45 67
F 89 ab cd ef
R 00000000 78563412
R 0000000c efcdab89
W 00000100 11223344 f
W 00000104 aabbccdd f
W 00000100 99887766 5
R 00000100 11883366
W 00000104 55443322 a
R 00000104 55bb33dd
J abc 123
R 02000018 0abc0123
R 02000020 00000000
O 1
W 02000000 02000000 f
O 0
W 02000000 01000000 e
O 0
W 02000000 01000000 1
O 1
W 02000000 00000000 f
O 1
L 0
W 02000010 00000001 f
L 1
W 02000014 00325a81 f
W 02000014 003fffff f
W 02000014 12001fff f
M 81 a 2 3fffff 001fff
W 02000014 44332211 f
W 02000014 88776655 f
B 11 22 33 44
B 55 66 77 88
W 02000010 00000000 f
L 0

/* tests/iosys_tb.sv */
`timescale 1ns/1ps

// iosys core testbench
// spi flash and sdram models, plays records from the golden file
// and checks boot copy, sdram bridge, i/o registers and rom loading
module iosys_tb;

    localparam int          fw_bytes  = 16;
    localparam logic [23:0] fl_addr   = 24'h50_0000;

    logic wclk, resetn, mem_valid, mem_ready, rv_rd, rv_wr, ram_busy, overlay, boot_done;
    logic cs_n, sck, mosi, miso, rom_loading, rom_do_valid;
    iosys_map_pkg::bus_addr_t   mem_addr;
    iosys_map_pkg::bus_data_t   mem_wdata, mem_rdata;
    iosys_map_pkg::bus_strb_t   mem_wstrb;
    iosys_map_pkg::sdram_addr_t rv_addr;
    iosys_map_pkg::sdram_data_t rv_din, rv_dout;
    logic [1:0]  rv_ds;
    logic [11:0] joy1, joy2;
    logic [7:0]  rom_do, map_ctrl;
    logic [3:0]  rom_size, ram_size;
    logic [23:0] rom_mask, ram_mask;

    // firmware image, records and models
    logic [7:0]  fw[$];
    byte         rec_kind[$];
    logic [31:0] rec_v[$][5];
    logic [15:0] sdram[int];
    logic [7:0]  rom_seen[$];
    int          cycles, limit;
    logic [31:0] cmd_sr;
    int          rx_bits, tx_bits;

    iosys_core #(.fw_bytes(fw_bytes), .fw_flash_addr(fl_addr)) dut (
        .wclk(wclk), .resetn(resetn), .mem_valid(mem_valid), .mem_ready(mem_ready),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_rdata(mem_rdata), .rv_addr(rv_addr), .rv_din(rv_din), .rv_ds(rv_ds),
        .rv_dout(rv_dout), .rv_rd(rv_rd), .rv_wr(rv_wr), .ram_busy(ram_busy),
        .flash_spi_cs_n(cs_n), .flash_spi_clk(sck), .flash_spi_mosi(mosi),
        .flash_spi_miso(miso), .joy1(joy1), .joy2(joy2), .rom_loading(rom_loading),
        .rom_do(rom_do), .rom_do_valid(rom_do_valid), .map_ctrl(map_ctrl),
        .rom_size(rom_size), .ram_size(ram_size), .rom_mask(rom_mask),
        .ram_mask(ram_mask), .overlay(overlay), .boot_done(boot_done)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input iosys_map_pkg::bus_data_t got,
                              input iosys_map_pkg::bus_data_t exp);
        if (got !== exp)
            fail_now($sformatf("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_half(input string name, input iosys_map_pkg::sdram_data_t got,
                              input iosys_map_pkg::sdram_data_t exp);
        if (got !== exp)
            fail_now($sformatf("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            fail_now($sformatf("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp));
    endtask

    // untouched sdram reads a pattern of the whole half-word index
    function automatic logic [15:0] fill_value(input logic [21:0] idx);
        return idx[15:0] ^ {idx[5:0], idx[21:12]} ^ 16'h5a5a;
    endfunction

    // sdram model with a two-cycle read return
    always @(posedge wclk) begin
        logic [21:0] idx;
        logic [15:0] w;
        idx = rv_addr[22:1];
        w   = sdram.exists(idx) ? sdram[idx] : fill_value(idx);
        if (rv_wr === 1'b1) begin
            if (rv_ds[0]) w[7:0] = rv_din[7:0];
            if (rv_ds[1]) w[15:8] = rv_din[15:8];
            sdram[idx] = w;
        end
        if (rv_rd === 1'b1) begin
            #2 rv_dout = w;
        end
    end

    // spi flash model in mode 0
    always @(negedge cs_n) begin
        rx_bits = 0;
        tx_bits = 0;
    end
    always @(posedge sck) begin
        if (cs_n === 1'b0 && rx_bits < 32) begin
            cmd_sr  = {cmd_sr[30:0], mosi};
            rx_bits = rx_bits + 1;
            if (rx_bits == 32 && cmd_sr !== {8'h03, fl_addr})
                fail_now("flash model got a wrong read command or address");
        end
    end
    always @(negedge sck) begin
        if (cs_n === 1'b0 && rx_bits == 32 && tx_bits < 8 * fw_bytes) begin
            miso    = fw[tx_bits / 8][7 - tx_bits % 8];
            tx_bits = tx_bits + 1;
        end
    end

    // collects rom bytes, watches ready during boot and counts cycles
    always @(posedge wclk) begin
        if (rom_do_valid === 1'b1) rom_seen.push_back(rom_do);
        if (resetn === 1'b1 && mem_ready === 1'b1 && boot_done !== 1'b1)
            fail_now("bus ready rose before the boot copy finished");
        cycles = cycles + 1;
        if (cycles > limit) fail_now("timeout, the run took too many cycles");
    end

    initial begin
        wclk = 1'b0;
        forever #20 wclk = ~wclk;
    end

    task automatic read_golden();
        int fd, n;
        string line, kind;
        logic [31:0] v[5];
        fd = $fopen("tests/iosys_golden.txt", "r");
        if (fd == 0) fail_now("cannot open the golden file");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%s %h %h %h %h %h", kind, v[0], v[1], v[2], v[3], v[4]);
            if (kind == "F") begin
                for (int i = 0; i < 4; i++) fw.push_back(v[i][7:0]);
            end
            rec_kind.push_back(kind[0]);
            rec_v.push_back(v);
        end
        $fclose(fd);
    endtask

    // one bus access started 2 ns after an edge
    task automatic bus_access(input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] s, output logic [31:0] r);
        mem_addr  = a;
        mem_wdata = d;
        mem_wstrb = s;
        mem_valid = 1'b1;
        do @(posedge wclk); while (mem_ready !== 1'b1);
        r = mem_rdata;
        #2 mem_valid = 1'b0;
        mem_wstrb = 4'd0;
    endtask

    task automatic next_rom_byte(input logic [7:0] exp);
        logic [7:0] got;
        while (rom_seen.size() == 0) @(posedge wclk);
        got = rom_seen.pop_front();
        check_byte("rom_do", got, exp);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] v[5];
        void'($urandom(19650));
        {mem_valid, mem_addr, mem_wdata, mem_wstrb} = '0;
        {rv_dout, miso, joy1, joy2} = '0;
        resetn   = 1'b0;
        ram_busy = 1'b1;
        cycles   = 0;
        limit    = 1 << 30;
        read_golden();
        limit = 64 + 20 * fw_bytes + 10 * rec_kind.size();
        repeat (3) @(posedge wclk);
        #2 resetn = 1'b1;
        // a joystick read held through the whole boot must wait
        mem_addr  = iosys_map_pkg::reg_joy_addr;
        mem_valid = 1'b1;
        repeat (10) @(posedge wclk);
        #2 sdram.delete();
        ram_busy = 1'b0;
        do @(posedge wclk); while (boot_done !== 1'b1);
        #2 mem_valid = 1'b0;
        for (int k = 0; k < fw_bytes / 2; k++)
            check_half("sdram boot half", sdram[k], {fw[2*k+1], fw[2*k]});
        foreach (rec_kind[i]) begin
            v = rec_v[i];
            case (rec_kind[i])
                "W": bus_access(v[0], v[1], v[2][3:0], r);
                "R": begin
                    bus_access(v[0], 32'd0, 4'd0, r);
                    check_word("mem_rdata", r, v[1]);
                end
                "J": begin
                    joy1 = v[0][11:0];
                    joy2 = v[1][11:0];
                end
                "O": check_bit("overlay", overlay, v[0][0]);
                "L": check_bit("rom_loading", rom_loading, v[0][0]);
                "B": for (int j = 0; j < 4; j++) next_rom_byte(v[j][7:0]);
                "M": begin
                    check_byte("map_ctrl", map_ctrl, v[0][7:0]);
                    check_byte("rom_size", {4'd0, rom_size}, v[1][7:0]);
                    check_byte("ram_size", {4'd0, ram_size}, v[2][7:0]);
                    check_word("rom_mask", {8'd0, rom_mask}, v[3]);
                    check_word("ram_mask", {8'd0, ram_mask}, v[4]);
                end
                default: ;
            endcase
            // random idle gap, none after a rom data write so data words stay back to back
            if (rec_kind[i] != "F"
                    && !(rec_kind[i] == "W" && v[0] == iosys_map_pkg::reg_romdata_addr)
                    && $urandom_range(0, 1) == 1) begin
                repeat ($urandom_range(1, 3)) @(posedge wclk);
                #2;
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule
